//--- tlb_pkg.sv
package tlb_pkg;

    ////////////////////////////////////////////////////////////////////
    // Sizes and codes
    ////////////////////////////////////////////////////////////////////

    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = 4;
    localparam int VPPN_W      = 19;
    localparam int PPN_W       = 20;
    localparam int ASID_W      = 10;
    localparam int PS_W        = 6;
    localparam int HUGE_LOW_W  = 10;

    // Page-size codes, log2 of the page size
    localparam logic [PS_W-1:0] PS_4K = PS_W'(12);
    localparam logic [PS_W-1:0] PS_4M = PS_W'(22);

    typedef enum logic [4:0] {
        INV_ALL0    = 5'd0,
        INV_ALL1    = 5'd1,
        INV_GLOBAL  = 5'd2,
        INV_PRIVATE = 5'd3,
        INV_ASID    = 5'd4,
        INV_ASID_VA = 5'd5,
        INV_GA      = 5'd6
    } inv_op_t;

    ////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    // Stored form, size kept as a single flag
    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              huge;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_view_t;

    // odd is VA bit 12
    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              odd;
        logic [ASID_W-1:0] asid;
    } tlb_query_t;

    typedef struct packed {
        logic             found;
        logic [IDX_W-1:0] index;
        logic [PS_W-1:0]  ps;
        tlb_page_t        page;
    } tlb_result_t;

endpackage

//--- tlb_entry_store.sv
`timescale 1ns/1ps

module tlb_entry_store (
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [tlb_pkg::IDX_W-1:0]            w_index,
    input  tlb_pkg::tlb_entry_view_t             w_entry,
    input  logic [tlb_pkg::IDX_W-1:0]            r_index,
    output tlb_pkg::tlb_entry_t                  entries [tlb_pkg::TLB_ENTRIES],
    output logic [tlb_pkg::TLB_ENTRIES-1:0]      g_vec,
    output tlb_pkg::tlb_entry_view_t             r_fields
);

    import tlb_pkg::*;

    tlb_entry_t w_fields;

    // Size code folded to one flag, anything but 22 is a 4 KB page
    always_comb begin
        w_fields.vppn  = w_entry.vppn;
        w_fields.huge  = (w_entry.ps == PS_4M);
        w_fields.asid  = w_entry.asid;
        w_fields.g     = w_entry.g;
        w_fields.page0 = w_entry.page0;
        w_fields.page1 = w_entry.page1;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entries[w_index] <= w_fields;
        end
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_bits
        assign g_vec[i] = entries[i].g;
    end

    ////////////////////////////////////////////////////////////////////
    // Indexed read, e is filled in by the top level
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        r_fields       = '0;
        r_fields.vppn  = entries[r_index].vppn;
        r_fields.ps    = entries[r_index].huge ? PS_4M : PS_4K;
        r_fields.asid  = entries[r_index].asid;
        r_fields.g     = entries[r_index].g;
        r_fields.page0 = entries[r_index].page0;
        r_fields.page1 = entries[r_index].page1;
    end

    // Only the two supported sizes may be written
    a_write_ps : assert property (@(posedge clk)
        we |-> (w_entry.ps == PS_4K || w_entry.ps == PS_4M))
        else $error("TLB write with unsupported page size %0d", w_entry.ps);

endmodule

//--- tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  tlb_pkg::tlb_query_t              query,
    input  tlb_pkg::tlb_entry_t              entries [tlb_pkg::TLB_ENTRIES],
    input  logic [tlb_pkg::TLB_ENTRIES-1:0]  exists,
    output tlb_pkg::tlb_result_t             result,
    output logic [tlb_pkg::TLB_ENTRIES-1:0]  va_hit,
    output logic [tlb_pkg::TLB_ENTRIES-1:0]  asid_hit
);

    import tlb_pkg::*;

    logic [TLB_ENTRIES-1:0] match;
    logic [TLB_ENTRIES-1:0] pick_odd;

    ////////////////////////////////////////////////////////////////////
    // Per-entry compare
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_cmp
        logic high_eq;
        logic low_eq;

        assign high_eq = (query.vppn[VPPN_W-1:HUGE_LOW_W]
                          == entries[i].vppn[VPPN_W-1:HUGE_LOW_W]);
        assign low_eq  = (query.vppn[HUGE_LOW_W-1:0]
                          == entries[i].vppn[HUGE_LOW_W-1:0]);

        // Huge pages ignore the low VPPN bits
        assign va_hit[i]   = high_eq && (entries[i].huge || low_eq);
        assign asid_hit[i] = (query.asid == entries[i].asid);
        assign match[i]    = va_hit[i] && (asid_hit[i] || entries[i].g) && exists[i];

        // Even/odd half, a 4 MB page splits on VPPN bit 9
        assign pick_odd[i] = entries[i].huge ? query.vppn[HUGE_LOW_W-1] : query.odd;
    end

    ////////////////////////////////////////////////////////////////////
    // Result encode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        result = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                result.found = 1'b1;
                result.index = IDX_W'(i);
                result.ps    = entries[i].huge ? PS_4M : PS_4K;
                result.page  = pick_odd[i] ? entries[i].page1 : entries[i].page0;
            end
        end
    end

    // Overlapping live entries would make the result meaningless
    always_comb begin
        a_one_match : assert final ($onehot0(match))
            else $error("TLB lookup matched several entries: %b", match);
    end

endmodule

//--- tlb_valid_ctrl.sv
`timescale 1ns/1ps

module tlb_valid_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                we,
    input  logic [tlb_pkg::IDX_W-1:0]           w_index,
    input  logic                                w_e,
    input  logic                                invtlb_valid,
    input  tlb_pkg::inv_op_t                    invtlb_op,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0]     g_vec,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0]     va_hit,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0]     asid_hit,
    output logic [tlb_pkg::TLB_ENTRIES-1:0]     exists
);

    import tlb_pkg::*;

    logic [TLB_ENTRIES-1:0] clean;

    ////////////////////////////////////////////////////////////////////
    // Invalidate decode
    ////////////////////////////////////////////////////////////////////

    // ASID and VA hits come from search port 1
    always_comb begin
        case (invtlb_op)
            INV_ALL0,
            INV_ALL1:    clean = '1;
            INV_GLOBAL:  clean = g_vec;
            INV_PRIVATE: clean = ~g_vec;
            INV_ASID:    clean = ~g_vec & asid_hit;
            INV_ASID_VA: clean = ~g_vec & asid_hit & va_hit;
            INV_GA:      clean = (g_vec | asid_hit) & va_hit;
            default:     clean = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Exists bits
    ////////////////////////////////////////////////////////////////////

    // Write assignment comes last so it overrides a same-cycle clean
    always_ff @(posedge clk) begin
        if (rst) begin
            exists <= '0;
        end else begin
            if (invtlb_valid) begin
                exists <= exists & ~clean;
            end
            if (we) begin
                exists[w_index] <= w_e;
            end
        end
    end

    a_inv_op : assert property (@(posedge clk) disable iff (rst)
        invtlb_valid |-> (invtlb_op <= INV_GA))
        else $error("Invalidate with unknown op %0d", invtlb_op);

endmodule

//--- tlb_top.sv
`timescale 1ns/1ps

module tlb_top (
    input  logic                        clk,
    input  logic                        rst,

    // Search port 0 for fetch
    input  tlb_pkg::tlb_query_t         s0_query,
    output tlb_pkg::tlb_result_t        s0_result,

    // Search port 1 for load/store, also feeds invalidate
    input  tlb_pkg::tlb_query_t         s1_query,
    output tlb_pkg::tlb_result_t        s1_result,

    // Write port
    input  logic                        we,
    input  logic [tlb_pkg::IDX_W-1:0]   w_index,
    input  tlb_pkg::tlb_entry_view_t    w_entry,

    // Read port
    input  logic [tlb_pkg::IDX_W-1:0]   r_index,
    output tlb_pkg::tlb_entry_view_t    r_entry,

    input  logic                        invtlb_valid,
    input  tlb_pkg::inv_op_t            invtlb_op
);

    import tlb_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    tlb_entry_view_t        r_fields;
    logic [TLB_ENTRIES-1:0] g_vec;
    logic [TLB_ENTRIES-1:0] exists;
    logic [TLB_ENTRIES-1:0] s1_va_hit;
    logic [TLB_ENTRIES-1:0] s1_asid_hit;

    ////////////////////////////////////////////////////////////////////
    // Entry fields
    ////////////////////////////////////////////////////////////////////

    tlb_entry_store u_entry_store (
        .clk      (clk),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (r_index),
        .entries  (entries),
        .g_vec    (g_vec),
        .r_fields (r_fields)
    );

    ////////////////////////////////////////////////////////////////////
    // Search ports
    ////////////////////////////////////////////////////////////////////

    tlb_lookup u_lookup0 (
        .query    (s0_query),
        .entries  (entries),
        .exists   (exists),
        .result   (s0_result),
        .va_hit   (),
        .asid_hit ()
    );

    tlb_lookup u_lookup1 (
        .query    (s1_query),
        .entries  (entries),
        .exists   (exists),
        .result   (s1_result),
        .va_hit   (s1_va_hit),
        .asid_hit (s1_asid_hit)
    );

    tlb_valid_ctrl u_valid_ctrl (
        .clk          (clk),
        .rst          (rst),
        .we           (we),
        .w_index      (w_index),
        .w_e          (w_entry.e),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .g_vec        (g_vec),
        .va_hit       (s1_va_hit),
        .asid_hit     (s1_asid_hit),
        .exists       (exists)
    );

    // Read view with e from the control block
    always_comb begin
        r_entry   = r_fields;
        r_entry.e = exists[r_index];
    end

endmodule

//--- tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb;

    import tlb_pkg::*;

    logic                   clk;
    logic                   rst;
    tlb_query_t             s0_query;
    tlb_query_t             s1_query;
    tlb_result_t            s0_result;
    tlb_result_t            s1_result;
    logic                   we;
    logic [IDX_W-1:0]       w_index;
    tlb_entry_view_t        w_entry;
    logic [IDX_W-1:0]       r_index;
    tlb_entry_view_t        r_entry;
    logic                   invtlb_valid;
    inv_op_t                invtlb_op;

    tlb_entry_view_t        ref_view [TLB_ENTRIES];
    tlb_entry_view_t        cur [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ref_e;
    logic [TLB_ENTRIES-1:0] ref_written = '0;
    int                     errors = 0;
    int                     timeouts = 0;

    tlb_top u_tlb_top (.*);

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic va_match(tlb_entry_view_t v, logic [VPPN_W-1:0] vppn);
        logic high_eq;
        logic low_eq;
        high_eq = (v.vppn[VPPN_W-1:HUGE_LOW_W] == vppn[VPPN_W-1:HUGE_LOW_W]);
        low_eq  = (v.vppn[HUGE_LOW_W-1:0] == vppn[HUGE_LOW_W-1:0]);
        return high_eq && (v.ps == PS_4M || low_eq);
    endfunction

    function automatic tlb_result_t expect_result(tlb_query_t q);
        tlb_result_t res;
        logic        odd;
        res = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ref_e[i] && va_match(ref_view[i], q.vppn)
                && (ref_view[i].g || ref_view[i].asid == q.asid)) begin
                // 4 MB pages split on VPPN bit 9
                odd       = (ref_view[i].ps == PS_4M) ? q.vppn[9] : q.odd;
                res.found = 1'b1;
                res.index = IDX_W'(i);
                res.ps    = ref_view[i].ps;
                res.page  = odd ? ref_view[i].page1 : ref_view[i].page0;
            end
        end
        return res;
    endfunction

    function automatic logic inv_clears(inv_op_t op, tlb_entry_view_t v, tlb_query_t q);
        logic same_asid;
        same_asid = (v.asid == q.asid);
        case (op)
            INV_ALL0, INV_ALL1: return 1'b1;
            INV_GLOBAL:  return v.g;
            INV_PRIVATE: return !v.g;
            INV_ASID:    return !v.g && same_asid;
            INV_ASID_VA: return !v.g && same_asid && va_match(v, q.vppn);
            INV_GA:      return (v.g || same_asid) && va_match(v, q.vppn);
            default:     return 1'b0;
        endcase
    endfunction

    // Write overrides a same-cycle invalidate
    always @(posedge clk) begin
        if (rst) begin
            ref_e = '0;
        end else begin
            if (invtlb_valid) begin
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (ref_e[i] && inv_clears(invtlb_op, ref_view[i], s1_query)) begin
                        ref_e[i] = 1'b0;
                    end
                end
            end
            if (we) begin
                ref_view[w_index]    = w_entry;
                ref_e[w_index]       = w_entry.e;
                ref_written[w_index] = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        tlb_entry_view_t exp_r;
        if (!rst) begin
            assert (s0_result === expect_result(s0_query)) else begin
                errors++;
                $display("Fail at %0t: port 0 result %h, expected %h", $time,
                         s0_result, expect_result(s0_query));
            end
            assert (s1_result === expect_result(s1_query)) else begin
                errors++;
                $display("Fail at %0t: port 1 result %h, expected %h", $time,
                         s1_result, expect_result(s1_query));
            end
            exp_r   = ref_view[r_index];
            exp_r.e = ref_e[r_index];
            // Fields of a never written entry are undefined
            assert (ref_written[r_index] ? r_entry === exp_r : r_entry.e === exp_r.e) else begin
                errors++;
                $display("Fail at %0t: read of entry %0d gave %h, expected %h", $time,
                         r_index, r_entry, exp_r);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic step(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_reset_clear(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 10) begin
            @(negedge clk);
            ok = (s0_result.found === 1'b0) && (s1_result.found === 1'b0)
                 && (r_entry.e === 1'b0);
            n++;
        end
        if (!ok) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the TLB to leave reset", n);
        end
    endtask

    // Index in VPPN bits 13:10 keeps entries from overlapping
    function automatic tlb_entry_view_t make_entry(int idx, logic huge,
                                                   logic [ASID_W-1:0] asid, logic g);
        tlb_entry_view_t v;
        v.e     = 1'b1;
        v.vppn  = {5'($urandom()), 4'(idx), 10'($urandom())};
        v.ps    = huge ? PS_4M : PS_4K;
        v.asid  = asid;
        v.g     = g;
        v.page0 = 26'($urandom());
        v.page1 = 26'($urandom());
        return v;
    endfunction

    function automatic tlb_query_t hit_query(tlb_entry_view_t v, logic [ASID_W-1:0] asid,
                                             logic miss);
        tlb_query_t q;
        q.vppn = v.vppn;
        if (v.ps == PS_4M) begin
            q.vppn[HUGE_LOW_W-1:0] = 10'($urandom());
        end
        q.vppn[VPPN_W-1] = q.vppn[VPPN_W-1] ^ miss;
        q.odd  = 1'($urandom());
        q.asid = asid;
        return q;
    endfunction

    task automatic apply_query(tlb_query_t q0, tlb_query_t q1, int ri);
        @(posedge clk);
        s0_query <= q0;
        s1_query <= q1;
        r_index  <= IDX_W'(ri);
    endtask

    task automatic issue_cycle(logic inv, inv_op_t op, tlb_query_t q, logic wr, int idx,
                               tlb_entry_view_t v);
        @(posedge clk);
        invtlb_valid <= inv;
        invtlb_op    <= op;
        s1_query     <= q;
        we           <= wr;
        w_index      <= IDX_W'(idx);
        w_entry      <= v;
        @(posedge clk);
        invtlb_valid <= 1'b0;
        we           <= 1'b0;
    endtask

    // Two ASIDs alternate by index parity
    task automatic refill(logic [ASID_W-1:0] a, logic [ASID_W-1:0] b, logic any_g,
                          logic any_huge);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            cur[i] = make_entry(i, any_huge & 1'($urandom()), i[0] ? b : a,
                                any_g & 1'($urandom()));
            issue_cycle(1'b0, INV_ALL0, s1_query, 1'b1, i, cur[i]);
        end
    endtask

    task automatic scan_entries();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            apply_query(hit_query(cur[i], cur[i].asid, 1'b0),
                        hit_query(cur[i], cur[i].asid ^ ASID_W'(1), 1'b0), i);
            apply_query(hit_query(cur[i], cur[i].asid, 1'b1),
                        hit_query(cur[i], cur[i].asid, 1'b0), i);
        end
    endtask

    initial begin
        logic              ok;
        logic [ASID_W-1:0] asid_a;
        logic [ASID_W-1:0] asid_b;
        tlb_query_t        q;
        void'($urandom(71));
        clk          = 1'b0;
        rst          = 1'b1;
        we           = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        s0_query     = '0;
        s1_query     = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = INV_ALL0;
        asid_a       = 10'($urandom());
        asid_b       = asid_a ^ ASID_W'(3);
        step(3);
        rst <= 1'b0;
        wait_reset_clear(ok);
        if (ok) begin
            for (int i = 0; i < 32; i++) begin
                apply_query(30'($urandom()), 30'($urandom()), i % TLB_ENTRIES);
            end
            // Plain 4 KB pages before mixed sizes and global entries
            refill(asid_a, asid_a, 1'b0, 1'b0);
            scan_entries();
            refill(asid_a, asid_a, 1'b0, 1'b1);
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                for (int k = 0; k < 4; k++) begin
                    q = hit_query(cur[i], asid_a, 1'b0);
                    q.vppn[9] = k[0];
                    apply_query(q, hit_query(cur[i], asid_a, 1'b1), i);
                end
            end
            refill(asid_a, asid_b, 1'b1, 1'b1);
            scan_entries();

            ////////////////////////////////////////////////////////////////
            // Invalidate ops
            ////////////////////////////////////////////////////////////////

            for (int op = 0; op < 7; op++) begin
                refill(asid_a, asid_b, 1'b1, 1'b1);
                q = hit_query(cur[$urandom() % TLB_ENTRIES], asid_a, 1'b0);
                issue_cycle(1'b1, inv_op_t'(op), q, 1'b0, 0, cur[0]);
                scan_entries();
            end
            // Unknown op presented on an idle strobe
            refill(asid_a, asid_b, 1'b1, 1'b1);
            issue_cycle(1'b0, inv_op_t'(5'd9), q, 1'b0, 0, cur[0]);
            scan_entries();
            // Write to entry 5 during a full invalidate keeps it alive
            issue_cycle(1'b1, INV_ALL1, q, 1'b1, 5, cur[5]);
            scan_entries();
        end
        step(2);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim.f
tlb_pkg.sv
tlb_entry_store.sv
tlb_lookup.sv
tlb_valid_ctrl.sv
tlb_top.sv
tb_tlb.sv

//--- Makefile
TOP = tb_tlb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
